/* flist.f */
+incdir+.
caf_pkg.sv
sample_buffer.sv
freq_shift.sv
x_corr.sv
peak_select.sv
caf.sv
tb_caf.sv

/* Makefile */
# Verilator build and run of the CAF testbench

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -Wno-fatal -j 0 --top-module tb_caf -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_caf | tee sim.log
	grep -q "^Done: no errors$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module caf -f flist.f

clean:
	rm -rf obj_dir sim.log

/* tb_caf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "caf_config.svh"

module tb_caf;

   import caf_pkg::*;

   localparam int CAP_LEN     = `CAF_CAP_LEN;
   localparam int REF_LEN     = `CAF_REF_LEN;
   localparam int LAGS        = `CAF_LAGS;
   localparam int CORR_CYCLES = LAGS * REF_LEN + 4;
   localparam int RUN_CYCLES  = 2 * CAP_LEN + REF_LEN + CORR_CYCLES + 4;  // stalls at most double capture
   localparam int NUM_RUNS    = 8;
   localparam int WATCHDOG_NS = 2 * (NUM_RUNS * RUN_CYCLES + 20) * 40;

   logic        clk;
   logic        rst_n;
   logic        ref_we;
   ref_addr_t   ref_addr;
   ref_sample_t ref_data;
   logic        in_valid;
   cap_sample_t in_data;
   logic        in_ready;
   logic        peak_valid;
   mag_t        peak_mag;
   lag_t        peak_lag;
   logic        peak_bin;

   int seed   = 32'h03dc_193a;
   int errors = 0;
   int checks = 0;
   int cyc    = 0;
   int cap_i [CAP_LEN];
   int cap_q [CAP_LEN];
   int ref_i [REF_LEN];
   int ref_q [REF_LEN];
   int base_mag;  // unstalled lag 5 result
   int base_lag;
   int base_bin;

   caf u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .ref_we     (ref_we),
      .ref_addr   (ref_addr),
      .ref_data   (ref_data),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_ready   (in_ready),
      .peak_valid (peak_valid),
      .peak_mag   (peak_mag),
      .peak_lag   (peak_lag),
      .peak_bin   (peak_bin)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic compare_value(input string what, input int got, input int expected);
      checks++;
      assert (got == expected) else begin
         errors++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
      end
   endtask

   task automatic expect_true(input bit ok, input string msg);
      checks++;
      assert (ok) else begin
         errors++;
         $display("Failure at %0t: %s", $time, msg);
      end
   endtask

   // multiply i + jq by j^r
   task automatic rotate(input int i, input int q, input int r, output int oi, output int oq);
      case (r % 4)
         0: begin
            oi = i;
            oq = q;
         end
         1: begin
            oi = -q;
            oq = i;
         end
         2: begin
            oi = -i;
            oq = -q;
         end
         default: begin
            oi = q;
            oq = -i;
         end
      endcase
   endtask

   // every lag and lane, strictly greater wins so earlier lag and lane 0 keep ties
   task automatic model_peak(output int mag, output int lag, output int bin);
      int steps [2];
      int s_re;
      int s_im;
      int yi;
      int yq;
      int m;
      steps[0] = 0;
      steps[1] = `CAF_STEP_1;
      mag = 0;
      lag = 0;
      bin = 0;
      for (int l = 0; l < LAGS; l++) begin
         for (int b = 0; b < 2; b++) begin
            s_re = 0;
            s_im = 0;
            for (int k = 0; k < REF_LEN; k++) begin
               rotate(cap_i[l+k], cap_q[l+k], steps[b] * (l + k), yi, yq);
               s_re += yi * ref_i[k] + yq * ref_q[k];
               s_im += yq * ref_i[k] - yi * ref_q[k];
            end
            m = ((s_re < 0) ? -s_re : s_re) + ((s_im < 0) ? -s_im : s_im);
            if (m > mag) begin
               mag = m;
               lag = l;
               bin = b;
            end
         end
      end
   endtask

   task automatic load_reference();
      for (int k = 0; k < REF_LEN; k++) begin
         @(negedge clk);
         ref_we   = 1'b1;
         ref_addr = ref_addr_t'(k);
         ref_data = {ref_i[k][`CAF_REF_BITS-1:0], ref_q[k][`CAF_REF_BITS-1:0]};
      end
      @(negedge clk);
      ref_we = 1'b0;
   endtask

   // real reference with alternating signs, so every partial overlap is weaker
   task automatic pulse_reference();
      int sign [8] = '{1, -1, 1, 1, -1, 1, -1, -1};
      for (int k = 0; k < REF_LEN; k++) begin
         ref_i[k] = 7 * sign[k % 8];
         ref_q[k] = 0;
      end
   endtask

   // scaled reference at lag, optionally turned against lane 1
   task automatic embed_reference(input int lag, input bit pre_rot);
      int n;
      for (n = 0; n < CAP_LEN; n++) begin
         cap_i[n] = 0;
         cap_q[n] = 0;
      end
      for (int k = 0; k < REF_LEN; k++) begin
         n = lag + k;
         rotate(8 * ref_i[k], 8 * ref_q[k], pre_rot ? 4 - ((`CAF_STEP_1 * n) % 4) : 0,
                cap_i[n], cap_q[n]);
      end
   endtask

   task automatic run_burst(input bit stall, input bit junk, output int mag, output int lag,
                            output int bin, output int latency);
      int idx;
      int hs_cycle;
      int r;
      bit rdy;
      bit seen;
      idx = 0;
      hs_cycle = 0;
      seen = 1'b0;
      while (idx < CAP_LEN) begin
         @(negedge clk);
         rdy = in_ready;  // holds until the next rising edge
         r = $random(seed);
         if (stall && r[1:0] == 2'b00) begin
            in_valid = 1'b0;
         end else begin
            in_valid = 1'b1;
            in_data  = {cap_i[idx][`CAF_CAP_BITS-1:0], cap_q[idx][`CAF_CAP_BITS-1:0]};
            if (rdy) begin
               idx++;
               hs_cycle = cyc + 1;  // handshake on the coming edge
            end
         end
      end
      while (!seen) begin
         @(negedge clk);
         if (peak_valid) begin
            seen     = 1'b1;
            in_valid = 1'b0;
            latency  = cyc - hs_cycle;
            mag      = int'(peak_mag);
            lag      = int'(peak_lag);
            bin      = int'(peak_bin);
         end else begin
            expect_true(!in_ready, "in_ready high while the correlation runs");
            r = $random(seed);
            in_valid = junk && r[0];  // offered samples must be ignored
            in_data  = r[2*`CAF_CAP_BITS-1:0];
         end
      end
      @(negedge clk);
      expect_true(!peak_valid, "peak_valid held for more than one cycle");
      expect_true(in_ready, "in_ready did not return after the result");
   endtask

   task automatic verify_burst(input bit stall, input bit junk, output int mag,
                               output int lag, output int bin);
      int latency;
      int e_mag;
      int e_lag;
      int e_bin;
      run_burst(stall, junk, mag, lag, bin, latency);
      model_peak(e_mag, e_lag, e_bin);
      compare_value("peak_mag", mag, e_mag);
      compare_value("peak_lag", lag, e_lag);
      compare_value("peak_bin", bin, e_bin);
      compare_value("cycles from last sample to peak_valid", latency, CORR_CYCLES);
   endtask

   task automatic idle_after_reset();
      expect_true(in_ready, "in_ready low after reset");
      expect_true(!peak_valid, "peak_valid high after reset");
      pulse_reference();
      load_reference();
      repeat (4) begin
         @(negedge clk);
         expect_true(in_ready && !peak_valid, "reference load disturbed the idle engine");
      end
   endtask

   task automatic unshifted_match();
      embed_reference(5, 1'b0);
      verify_burst(1'b0, 1'b0, base_mag, base_lag, base_bin);
      compare_value("unshifted peak_lag", base_lag, 5);
      compare_value("unshifted peak_bin", base_bin, 0);
   endtask

   task automatic shifted_match();
      int mag;
      int lag;
      int bin;
      embed_reference(3, 1'b1);
      verify_burst(1'b0, 1'b0, mag, lag, bin);
      compare_value("shifted peak_lag", lag, 3);
      compare_value("shifted peak_bin", bin, 1);
   endtask

   task automatic stalled_match();
      int mag;
      int lag;
      int bin;
      embed_reference(5, 1'b0);
      verify_burst(1'b1, 1'b1, mag, lag, bin);
      compare_value("stalled peak_mag", mag, base_mag);
      compare_value("stalled peak_lag", lag, base_lag);
      compare_value("stalled peak_bin", bin, base_bin);
   endtask

   task automatic random_bursts();
      int r;
      int mag;
      int lag;
      int bin;
      for (int b = 0; b < 5; b++) begin
         for (int k = 0; k < REF_LEN; k++) begin
            r = $random(seed);
            ref_i[k] = r % 8;
            r = $random(seed);
            ref_q[k] = r % 8;
         end
         for (int n = 0; n < CAP_LEN; n++) begin
            if (b == 3 && n >= 4) begin
               cap_i[n] = cap_i[n % 4];  // period 4, so lags l and l+4 tie
               cap_q[n] = cap_q[n % 4];
            end else begin
               r = $random(seed);
               cap_i[n] = r % 128;
               r = $random(seed);
               cap_q[n] = r % 128;
            end
         end
         load_reference();
         verify_burst(1'b0, 1'b0, mag, lag, bin);
         if (b == 3) begin
            expect_true(lag < 4, "tie between periodic lags not won by the earliest lag");
         end
      end
   endtask

   initial begin
      rst_n    = 1'b0;
      ref_we   = 1'b0;
      ref_addr = '0;
      ref_data = '0;
      in_valid = 1'b0;
      in_data  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      idle_after_reset();
      unshifted_match();
      shifted_match();
      stalled_match();
      random_bursts();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* caf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "caf_config.svh"

module caf (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 ref_we,
   input  caf_pkg::ref_addr_t   ref_addr,
   input  caf_pkg::ref_sample_t ref_data,
   input  logic                 in_valid,
   input  caf_pkg::cap_sample_t in_data,
   output logic                 in_ready,
   output logic                 peak_valid,
   output caf_pkg::mag_t        peak_mag,
   output caf_pkg::lag_t        peak_lag,
   output logic                 peak_bin
);

   import caf_pkg::*;

   caf_state_t  state;
   caf_state_t  state_nxt;
   cap_addr_t   wr_cnt;
   lag_t        lag_cnt;
   ref_addr_t   iter;
   logic        in_fire;
   logic        rd_en;
   logic        rd_first;
   logic        rd_last;
   logic        rd_done;
   cap_addr_t   rd_cap_addr;
   cap_sample_t cap_rdata;
   logic        cap_rvalid;
   ref_sample_t ref_rdata;
   logic        ref_rvalid;
   ref_sample_t ref_q;
   cap_addr_t   index_d;
   lag_t        lag_d1;
   lag_t        lag_d2;
   logic        first_d;
   logic        last_d;
   logic [3:0]  done_sr;
   logic [1:0]  sh_valid;
   cap_sample_t sh_sample [2];
   logic [1:0]  sh_first;
   logic [1:0]  sh_last;
   logic [1:0]  lane_valid;
   mag_t        lane_mag [2];
   lag_t        lane_lag [2];

   assign in_fire     = in_valid && in_ready;
   assign rd_en       = (state == CORRELATE);
   assign rd_cap_addr = cap_addr_t'(lag_cnt) + cap_addr_t'(iter);
   assign rd_first    = rd_en && (iter == '0);
   assign rd_last     = rd_en && (iter == ref_addr_t'(`CAF_REF_LEN - 1));
   assign rd_done     = rd_last && (lag_cnt == lag_t'(`CAF_LAGS - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: if (in_fire) state_nxt = CAPTURE;
         CAPTURE: begin
            if (in_fire && wr_cnt == cap_addr_t'(`CAF_CAP_LEN - 1)) begin
               state_nxt = CORRELATE;
            end
         end
         CORRELATE: if (rd_done) state_nxt = REPORT;
         REPORT: if (peak_valid) state_nxt = IDLE;  // back to idle after the pulse
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         in_ready <= 1'b0;
         wr_cnt   <= '0;
         lag_cnt  <= '0;
         iter     <= '0;
         first_d  <= 1'b0;
         last_d   <= 1'b0;
         done_sr  <= '0;
      end else begin
         state    <= state_nxt;
         in_ready <= (state_nxt == IDLE) || (state_nxt == CAPTURE);
         if (in_fire) begin
            wr_cnt <= (wr_cnt == cap_addr_t'(`CAF_CAP_LEN - 1)) ? '0 : wr_cnt + 1'b1;
         end
         if (rd_last) begin
            iter    <= '0;
            lag_cnt <= rd_done ? '0 : lag_cnt + 1'b1;
         end else if (rd_en) begin
            iter <= iter + 1'b1;
         end
         first_d <= rd_first;  // aligned with the buffer read data
         last_d  <= rd_last;
         done_sr <= {done_sr[2:0], rd_done};  // ram + shifter + two x_corr stages
      end
   end

   always_ff @(posedge clk) begin
      index_d <= rd_cap_addr;
      lag_d1  <= lag_cnt;
      lag_d2  <= lag_d1;  // matches the shifter output
      if (ref_rvalid) begin
         ref_q <= ref_rdata;
      end
   end

   sample_buffer #(
      .payload_t (cap_sample_t),
      .DEPTH     (`CAF_CAP_LEN)
   ) u_cap_buf (
      .clk    (clk),
      .we     (in_fire),
      .waddr  (wr_cnt),
      .wdata  (in_data),
      .re     (rd_en),
      .raddr  (rd_cap_addr),
      .rdata  (cap_rdata),
      .rvalid (cap_rvalid)
   );

   sample_buffer #(
      .payload_t (ref_sample_t),
      .DEPTH     (`CAF_REF_LEN)
   ) u_ref_buf (
      .clk    (clk),
      .we     (ref_we),
      .waddr  (ref_addr),
      .wdata  (ref_data),
      .re     (rd_en),
      .raddr  (iter),
      .rdata  (ref_rdata),
      .rvalid (ref_rvalid)
   );

   for (genvar g = 0; g < 2; g++) begin : g_lane
      freq_shift #(
         .STEP ((g == 0) ? 0 : `CAF_STEP_1)
      ) u_shift (
         .clk        (clk),
         .rst_n      (rst_n),
         .in_valid   (cap_rvalid),
         .in_sample  (cap_rdata),
         .in_index   (index_d),
         .in_first   (first_d),
         .in_last    (last_d),
         .out_valid  (sh_valid[g]),
         .out_sample (sh_sample[g]),
         .out_first  (sh_first[g]),
         .out_last   (sh_last[g])
      );

      x_corr u_corr (
         .clk        (clk),
         .rst_n      (rst_n),
         .in_valid   (sh_valid[g]),
         .in_sample  (sh_sample[g]),
         .ref_sample (ref_q),
         .in_first   (sh_first[g]),
         .in_last    (sh_last[g]),
         .lag        (lag_d2),
         .mag_valid  (lane_valid[g]),
         .mag        (lane_mag[g]),
         .mag_lag    (lane_lag[g])
      );
   end

   peak_select u_peak (
      .clk        (clk),
      .rst_n      (rst_n),
      .mag_valid  (lane_valid[0]),
      .mag0       (lane_mag[0]),
      .mag1       (lane_mag[1]),
      .mag_lag    (lane_lag[0]),
      .done       (done_sr[3]),
      .peak_valid (peak_valid),
      .peak_mag   (peak_mag),
      .peak_lag   (peak_lag),
      .peak_bin   (peak_bin)
   );

   a_ready_window : assert property (
      @(posedge clk) disable iff (!rst_n)
      !((state == IDLE) || (state == CAPTURE)) |-> !in_ready
   ) else $error("in_ready high during correlation");

endmodule

`default_nettype wire

/* peak_select.sv */
`timescale 1ns/1ps
`default_nettype none

module peak_select (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           mag_valid,
   input  caf_pkg::mag_t  mag0,
   input  caf_pkg::mag_t  mag1,
   input  caf_pkg::lag_t  mag_lag,
   input  logic           done,
   output logic           peak_valid,
   output caf_pkg::mag_t  peak_mag,
   output caf_pkg::lag_t  peak_lag,
   output logic           peak_bin
);

   import caf_pkg::*;

   mag_t best_mag;
   lag_t best_lag;
   logic best_bin;
   mag_t nxt_mag;
   lag_t nxt_lag;
   logic nxt_bin;

   // strictly greater, so earlier lags and lane 0 keep ties
   always_comb begin
      if (mag_lag == '0) begin
         nxt_mag = '0;  // new search starts at lag 0
         nxt_lag = '0;
         nxt_bin = 1'b0;
      end else begin
         nxt_mag = best_mag;
         nxt_lag = best_lag;
         nxt_bin = best_bin;
      end
      if (mag0 > nxt_mag) begin
         nxt_mag = mag0;
         nxt_lag = mag_lag;
         nxt_bin = 1'b0;
      end
      if (mag1 > nxt_mag) begin
         nxt_mag = mag1;
         nxt_lag = mag_lag;
         nxt_bin = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (mag_valid) begin
         best_mag <= nxt_mag;
         best_lag <= nxt_lag;
         best_bin <= nxt_bin;
      end
      if (mag_valid && done) begin
         peak_mag <= nxt_mag;
         peak_lag <= nxt_lag;
         peak_bin <= nxt_bin;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         peak_valid <= 1'b0;
      end else begin
         peak_valid <= mag_valid && done;
      end
   end

endmodule

`default_nettype wire

/* x_corr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "caf_config.svh"

module x_corr (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  caf_pkg::cap_sample_t in_sample,
   input  caf_pkg::ref_sample_t ref_sample,
   input  logic                 in_first,
   input  logic                 in_last,
   input  caf_pkg::lag_t        lag,
   output logic                 mag_valid,
   output caf_pkg::mag_t        mag,
   output caf_pkg::lag_t        mag_lag
);

   import caf_pkg::*;

   logic signed [`CAF_CAP_BITS-1:0] yi;
   logic signed [`CAF_CAP_BITS-1:0] yq;
   logic signed [`CAF_REF_BITS-1:0] ri;
   logic signed [`CAF_REF_BITS-1:0] rq;
   sum_t                            prod_re;
   sum_t                            prod_im;
   sum_t                            acc_re;
   sum_t                            acc_im;
   logic [`CAF_SUM_BITS-1:0]        abs_re;
   logic [`CAF_SUM_BITS-1:0]        abs_im;
   lag_t                            lag_q;
   logic                            last_q;
   logic                            span_open;

   assign yi = in_sample[2*`CAF_CAP_BITS-1 -: `CAF_CAP_BITS];
   assign yq = in_sample[`CAF_CAP_BITS-1:0];
   assign ri = ref_sample[2*`CAF_REF_BITS-1 -: `CAF_REF_BITS];
   assign rq = ref_sample[`CAF_REF_BITS-1:0];

   // y * conj(r) = (yi*ri + yq*rq) + j(yq*ri - yi*rq)
   assign prod_re = yi * ri + yq * rq;
   assign prod_im = yq * ri - yi * rq;

   // stage 1, accumulate over one reference span
   always_ff @(posedge clk) begin
      if (in_valid) begin
         if (in_first) begin
            acc_re <= prod_re;
            acc_im <= prod_im;
            lag_q  <= lag;  // lag of the span that starts here
         end else begin
            acc_re <= acc_re + prod_re;
            acc_im <= acc_im + prod_im;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_q    <= 1'b0;
         span_open <= 1'b0;
         mag_valid <= 1'b0;
      end else begin
         last_q    <= in_valid && in_last;
         mag_valid <= last_q;
         if (in_valid && in_last) begin
            span_open <= 1'b0;
         end else if (in_valid && in_first) begin
            span_open <= 1'b1;
         end
      end
   end

   // unsigned result, so -(-2^15) still reads as 2^15
   assign abs_re = acc_re[`CAF_SUM_BITS-1] ? -acc_re : acc_re;
   assign abs_im = acc_im[`CAF_SUM_BITS-1] ? -acc_im : acc_im;

   // stage 2, L1 magnitude of the finished sum
   always_ff @(posedge clk) begin
      if (last_q) begin
         mag     <= {1'b0, abs_re} + {1'b0, abs_im};
         mag_lag <= lag_q;
      end
   end

   a_span_closed : assert property (
      @(posedge clk) disable iff (!rst_n)
      (in_valid && in_first) |-> !span_open
   ) else $error("x_corr span restarted before its last sample");

endmodule

`default_nettype wire

/* freq_shift.sv */
`timescale 1ns/1ps
`default_nettype none

`include "caf_config.svh"

module freq_shift #(
   parameter int STEP = 0
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  caf_pkg::cap_sample_t in_sample,
   input  caf_pkg::cap_addr_t   in_index,
   input  logic                 in_first,
   input  logic                 in_last,
   output logic                 out_valid,
   output caf_pkg::cap_sample_t out_sample,
   output logic                 out_first,
   output logic                 out_last
);

   import caf_pkg::*;

   localparam logic [1:0] STEP_Q = 2'(STEP);

   logic [1:0]                      rot;
   logic signed [`CAF_CAP_BITS-1:0] xi;
   logic signed [`CAF_CAP_BITS-1:0] xq;
   logic signed [`CAF_CAP_BITS-1:0] oi;
   logic signed [`CAF_CAP_BITS-1:0] oq;
   cap_sample_t                     rot_sample;

   assign xi = in_sample[2*`CAF_CAP_BITS-1 -: `CAF_CAP_BITS];
   assign xq = in_sample[`CAF_CAP_BITS-1:0];

   // only the low two index bits matter mod 4
   assign rot = STEP_Q * in_index[1:0];

   // multiply by j^rot, negation wraps at the most negative value
   always_comb begin
      case (rot)
         2'd0: begin
            oi = xi;
            oq = xq;
         end
         2'd1: begin
            oi = -xq;
            oq = xi;
         end
         2'd2: begin
            oi = -xi;
            oq = -xq;
         end
         default: begin
            oi = xq;
            oq = -xi;
         end
      endcase
   end

   assign rot_sample = {oi, oq};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         out_first <= 1'b0;
         out_last  <= 1'b0;
      end else begin
         out_valid <= in_valid;
         out_first <= in_valid && in_first;
         out_last  <= in_valid && in_last;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         out_sample <= rot_sample;
      end
   end

endmodule

`default_nettype wire

/* sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 16
) (
   input  logic                                      clk,
   input  logic                                      we,
   input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] waddr,
   input  payload_t                                  wdata,
   input  logic                                      re,
   input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] raddr,
   output payload_t                                  rdata,
   output logic                                      rvalid
);

   payload_t mem [DEPTH];

   // write port, one entry per cycle
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // registered read, data and strobe one cycle after re
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[raddr];
      end
      rvalid <= re;
   end

   a_waddr_range : assert property (
      @(posedge clk) we |-> (int'(waddr) < DEPTH)
   ) else $error("sample_buffer write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

/* caf_pkg.sv */
`default_nettype none

`include "caf_config.svh"

package caf_pkg;

   // I in the upper half, Q in the lower half
   typedef logic [2*`CAF_CAP_BITS-1:0] cap_sample_t;
   typedef logic [2*`CAF_REF_BITS-1:0] ref_sample_t;

   typedef logic [$clog2(`CAF_CAP_LEN)-1:0] cap_addr_t;
   typedef logic [$clog2(`CAF_REF_LEN)-1:0] ref_addr_t;
   typedef logic [$clog2(`CAF_LAGS)-1:0]    lag_t;

   typedef logic signed [`CAF_SUM_BITS-1:0] sum_t;  // one component of a correlation sum

   // |re| + |im| needs one bit more than a component
   typedef logic [`CAF_SUM_BITS:0] mag_t;

   typedef enum logic [1:0] {
      IDLE,
      CAPTURE,
      CORRELATE,
      REPORT
   } caf_state_t;

endpackage

`default_nettype wire

/* caf_config.svh */
`ifndef CAF_CONFIG_SVH
`define CAF_CONFIG_SVH

// width of each I and Q component of a capture sample
`define CAF_CAP_BITS 8

// width of each I and Q component of a reference sample
`define CAF_REF_BITS 4

// buffer lengths in samples
`define CAF_CAP_LEN 16
`define CAF_REF_LEN 8

// every lag that keeps the reference inside the capture
`define CAF_LAGS (`CAF_CAP_LEN - `CAF_REF_LEN + 1)

// quarter-turn step of lane 1, 0 to 3
`define CAF_STEP_1 1

// per-component width of a correlation sum
`define CAF_SUM_BITS 16

`endif
